// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int data_width = 32;
    localparam int reg_count = 8;
    localparam int reg_index_width = $clog2(reg_count);
    localparam int opcode_width = 7;
    localparam int imm_width = 16;

    typedef logic [data_width-1:0] word_t;
    typedef logic flag_t;
    typedef logic [reg_index_width-1:0] reg_index_t;

    // opcode values outside this list decode as a no-op.
    typedef enum logic [opcode_width-1:0] {
        op_add   = 7'd0,
        op_sub   = 7'd1,
        op_and   = 7'd2,
        op_or    = 7'd3,
        op_xor   = 7'd4,
        op_ldi   = 7'd5,
        op_ldhi  = 7'd6,
        op_store = 7'd7,
        op_load  = 7'd8,
        op_cmplt = 7'd9,
        op_brf   = 7'd10,
        op_halt  = 7'd11
    } opcode_t;

    // Bit layout: imm [31:16], rd [15:13], rb [12:10], ra [9:7], opcode [6:0].
    typedef struct packed {
        logic [imm_width-1:0] imm; // immediate, or signed branch offset.
        reg_index_t rd;            // destination register and flag.
        reg_index_t rb;            // second source, or memory address register.
        reg_index_t ra;            // first source, or flag tested by a branch.
        opcode_t opcode;
    } instr_t;

    typedef enum logic [2:0] {
        alu_add       = 3'd0,
        alu_sub       = 3'd1,
        alu_and       = 3'd2,
        alu_or        = 3'd3,
        alu_xor       = 3'd4,
        alu_pass_b    = 3'd5,
        alu_less_than = 3'd6
    } alu_op_t;

    // the halted condition is kept in its own bit beside the state.
    typedef enum logic [1:0] {
        st_fetch    = 2'd0,
        st_decode   = 2'd1,
        st_execute  = 2'd2,
        st_mem_wait = 2'd3
    } state_t;

    typedef struct packed {
        word_t addr;  // word address.
        word_t wdata;
        logic re;     // read data returns one cycle later.
        logic we;
    } mem_req_t;

endpackage

// File: src/reg_bank.sv
`timescale 1ns/1ps

module reg_bank #(
    parameter type entry_t = cpu_pkg::word_t
) (
    input  logic                clock,
    input  logic                rst,
    input  cpu_pkg::reg_index_t rd_index_a,
    input  cpu_pkg::reg_index_t rd_index_b,
    input  logic                wr_en,
    input  cpu_pkg::reg_index_t wr_index,
    input  entry_t              wr_data,
    output entry_t              rd_data_a,
    output entry_t              rd_data_b
);

    entry_t entries [cpu_pkg::reg_count];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            entries <= '{default: '0};
        end
        else if (wr_en)
        begin
            entries[wr_index] <= wr_data;
        end
    end

    // both read ports are combinational, so a write shows up the cycle after.
    assign rd_data_a = entries[rd_index_a];
    assign rd_data_b = entries[rd_index_b];

    // An unknown value written here would poison every later read of the entry.
    assert property (@(posedge clock) disable iff (rst) wr_en |-> !$isunknown(wr_data))
        else $error("reg_bank: unknown write data to entry %0d", wr_index);

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   operand_a,
    input  cpu_pkg::word_t   operand_b,
    output cpu_pkg::word_t   result,
    output cpu_pkg::flag_t   flag
);

    logic [cpu_pkg::data_width:0] sum;
    logic [cpu_pkg::data_width:0] difference;

    // one extra bit on top holds the carry out or the borrow.
    assign sum = {1'b0, operand_a} + {1'b0, operand_b};
    assign difference = {1'b0, operand_a} - {1'b0, operand_b};

    always_comb
    begin
        result = '0;
        flag = 1'b0;
        case (op)
            cpu_pkg::alu_add:
            begin
                result = sum[cpu_pkg::data_width-1:0];
                flag = sum[cpu_pkg::data_width];
            end
            cpu_pkg::alu_sub:
            begin
                result = difference[cpu_pkg::data_width-1:0];
                flag = difference[cpu_pkg::data_width]; // set when b is larger than a.
            end
            cpu_pkg::alu_and:
            begin
                result = operand_a & operand_b;
            end
            cpu_pkg::alu_or:
            begin
                result = operand_a | operand_b;
            end
            cpu_pkg::alu_xor:
            begin
                result = operand_a ^ operand_b;
            end
            cpu_pkg::alu_pass_b:
            begin
                result = operand_b; // immediates arrive already formed on b.
            end
            cpu_pkg::alu_less_than:
            begin
                flag = (operand_a < operand_b); // unsigned, result stays zero.
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

endmodule

// File: src/cpu_control.sv
`timescale 1ns/1ps

module cpu_control (
    input  logic                clock,
    input  logic                rst,
    input  cpu_pkg::word_t      mem_rdata,
    input  cpu_pkg::word_t      reg_a,
    input  cpu_pkg::word_t      reg_b,
    input  cpu_pkg::flag_t      flag_a,
    output cpu_pkg::mem_req_t   mem_req,
    output cpu_pkg::reg_index_t rd_index_a,
    output cpu_pkg::reg_index_t rd_index_b,
    output logic                reg_wr_en,
    output logic                flag_wr_en,
    output cpu_pkg::reg_index_t wr_index,
    output cpu_pkg::alu_op_t    alu_op,
    output cpu_pkg::word_t      alu_operand_b,
    output logic                load_select,
    output logic                halted
);

    cpu_pkg::state_t state;
    cpu_pkg::word_t  pc;
    cpu_pkg::instr_t ir;
    cpu_pkg::instr_t cur_instr;
    cpu_pkg::word_t  branch_offset;
    logic            writes_reg;
    logic            writes_flag;

    // During decode the instruction is still on the read bus.
    assign cur_instr = (state == cpu_pkg::st_decode) ? cpu_pkg::instr_t'(mem_rdata) : ir;

    // ldhi keeps the low half of rd, so rd is read through port a.
    assign rd_index_a = (cur_instr.opcode == cpu_pkg::op_ldhi) ? cur_instr.rd : cur_instr.ra;
    assign rd_index_b = cur_instr.rb;
    assign wr_index = ir.rd;

    assign branch_offset = {{(cpu_pkg::data_width - cpu_pkg::imm_width){ir.imm[cpu_pkg::imm_width-1]}},
                            ir.imm};

    always_comb
    begin
        alu_op = cpu_pkg::alu_pass_b;
        writes_reg = 1'b0;
        writes_flag = 1'b0;
        case (ir.opcode)
            cpu_pkg::op_add:
            begin
                alu_op = cpu_pkg::alu_add;
                writes_reg = 1'b1;
                writes_flag = 1'b1;
            end
            cpu_pkg::op_sub:
            begin
                alu_op = cpu_pkg::alu_sub;
                writes_reg = 1'b1;
                writes_flag = 1'b1;
            end
            cpu_pkg::op_and:
            begin
                alu_op = cpu_pkg::alu_and;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_or:
            begin
                alu_op = cpu_pkg::alu_or;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_xor:
            begin
                alu_op = cpu_pkg::alu_xor;
                writes_reg = 1'b1;
            end
            cpu_pkg::op_ldi, cpu_pkg::op_ldhi:
            begin
                writes_reg = 1'b1; // value comes through pass_b.
            end
            cpu_pkg::op_cmplt:
            begin
                alu_op = cpu_pkg::alu_less_than;
                writes_flag = 1'b1;
            end
            default:
            begin
                writes_reg = 1'b0;
            end
        endcase
    end

    always_comb
    begin
        case (ir.opcode)
            cpu_pkg::op_ldi:  alu_operand_b = {{cpu_pkg::imm_width{1'b0}}, ir.imm};
            cpu_pkg::op_ldhi: alu_operand_b = {ir.imm, reg_a[cpu_pkg::imm_width-1:0]};
            default:          alu_operand_b = reg_b;
        endcase
    end

    assign reg_wr_en = ((state == cpu_pkg::st_execute) && writes_reg) ||
                       (state == cpu_pkg::st_mem_wait);
    assign flag_wr_en = (state == cpu_pkg::st_execute) && writes_flag;
    assign load_select = (state == cpu_pkg::st_mem_wait);

    always_comb
    begin
        mem_req = '0;
        if (!halted && state == cpu_pkg::st_fetch)
        begin
            mem_req.re = 1'b1;
            mem_req.addr = pc;
        end
        else if (!halted && state == cpu_pkg::st_execute)
        begin
            mem_req.addr = reg_b;
            mem_req.wdata = reg_a;
            mem_req.re = (ir.opcode == cpu_pkg::op_load);
            mem_req.we = (ir.opcode == cpu_pkg::op_store);
        end
    end

    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::st_decode)
        begin
            ir <= cpu_pkg::instr_t'(mem_rdata);
        end
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= cpu_pkg::st_fetch;
            pc <= '0;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            case (state)
                cpu_pkg::st_fetch:  state <= cpu_pkg::st_decode;
                cpu_pkg::st_decode: state <= cpu_pkg::st_execute;
                cpu_pkg::st_execute:
                begin
                    state <= cpu_pkg::st_fetch;
                    if (ir.opcode == cpu_pkg::op_load)
                        state <= cpu_pkg::st_mem_wait; // pc moves on once the data is in.
                    else if (ir.opcode == cpu_pkg::op_halt)
                        halted <= 1'b1; // pc stays on the halt instruction.
                    else if (ir.opcode == cpu_pkg::op_brf && flag_a)
                        pc <= pc + branch_offset;
                    else
                        pc <= pc + cpu_pkg::word_t'(1);
                end
                cpu_pkg::st_mem_wait:
                begin
                    pc <= pc + cpu_pkg::word_t'(1);
                    state <= cpu_pkg::st_fetch;
                end
                default: state <= cpu_pkg::st_fetch;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (rst) !(mem_req.re && mem_req.we))
        else $error("cpu_control: read and write requested together");

    // Once halted the core stays quiet on the bus until the next reset.
    assert property (@(posedge clock) disable iff (rst)
                     halted |=> halted && !mem_req.re && !mem_req.we)
        else $error("cpu_control: bus activity after halt");

endmodule

// File: src/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic              clock,
    input  logic              rst,
    input  cpu_pkg::word_t    mem_rdata,
    output cpu_pkg::mem_req_t mem_req,
    output logic              halted
);

    cpu_pkg::reg_index_t rd_index_a;
    cpu_pkg::reg_index_t rd_index_b;
    cpu_pkg::reg_index_t wr_index;
    logic                reg_wr_en;
    logic                flag_wr_en;
    logic                load_select;
    cpu_pkg::alu_op_t    alu_op;
    cpu_pkg::word_t      alu_operand_b;
    cpu_pkg::word_t      alu_result;
    cpu_pkg::flag_t      alu_flag;
    cpu_pkg::word_t      reg_a;
    cpu_pkg::word_t      reg_b;
    cpu_pkg::word_t      word_wr_data;
    cpu_pkg::flag_t      flag_a;

    assign word_wr_data = load_select ? mem_rdata : alu_result; // loads bypass the ALU.

    cpu_control control_inst (
        .clock         (clock),
        .rst           (rst),
        .mem_rdata     (mem_rdata),
        .reg_a         (reg_a),
        .reg_b         (reg_b),
        .flag_a        (flag_a),
        .mem_req       (mem_req),
        .rd_index_a    (rd_index_a),
        .rd_index_b    (rd_index_b),
        .reg_wr_en     (reg_wr_en),
        .flag_wr_en    (flag_wr_en),
        .wr_index      (wr_index),
        .alu_op        (alu_op),
        .alu_operand_b (alu_operand_b),
        .load_select   (load_select),
        .halted        (halted)
    );

    alu alu_inst (
        .op        (alu_op),
        .operand_a (reg_a),
        .operand_b (alu_operand_b),
        .result    (alu_result),
        .flag      (alu_flag)
    );

    reg_bank #(.entry_t(cpu_pkg::word_t)) word_bank (
        .clock      (clock),
        .rst        (rst),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .wr_en      (reg_wr_en),
        .wr_index   (wr_index),
        .wr_data    (word_wr_data),
        .rd_data_a  (reg_a),
        .rd_data_b  (reg_b)
    );

    // only port a of the flag bank is needed, for the branch test.
    reg_bank #(.entry_t(cpu_pkg::flag_t)) flag_bank (
        .clock      (clock),
        .rst        (rst),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .wr_en      (flag_wr_en),
        .wr_index   (wr_index),
        .wr_data    (alu_flag),
        .rd_data_a  (flag_a),
        .rd_data_b  ()
    );

endmodule

// File: tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int mem_words = 256;
    localparam int halt_cycles = 20;

    logic              clock;
    logic              rst;
    cpu_pkg::word_t    mem_rdata;
    cpu_pkg::mem_req_t mem_req;
    logic              halted;

    cpu_pkg::word_t mem [mem_words];
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];
    cpu_pkg::word_t halt_addr;
    cpu_pkg::word_t read_addr;
    cpu_pkg::word_t last_read_addr;
    logic           read_pending;
    int             prog_len;
    int             stores_seen;
    int             error_count;
    int             cycle_count = 0;
    int             cycle_limit;
    bit             stim_ok;

    cpu cpu_inst (
        .clock     (clock),
        .rst       (rst),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .halted    (halted)
    );

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count++;
    end

    task check_value(input string name, input cpu_pkg::word_t expected,
                     input cpu_pkg::word_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        if (stores_seen >= exp_addr.size())
        begin
            error_count++;
            $display("unexpected store number %0d to address %h, only %0d were expected",
                     stores_seen + 1, addr, exp_addr.size());
        end
        else
        begin
            check_value($sformatf("mem_req.addr of store %0d", stores_seen),
                        exp_addr[stores_seen], addr);
            check_value($sformatf("mem_req.wdata of store %0d", stores_seen),
                        exp_data[stores_seen], data);
        end
        stores_seen++;
    endtask

    // returns the next line that holds data, or an empty string at the end of the file.
    task automatic next_line(input int fd, output string line);
        string raw;
        line = "";
        while (line == "" && !$feof(fd))
        begin
            raw = "";
            if ($fgets(raw, fd) != 0 && raw.len() > 1 && raw.getc(0) != "#")
                line = raw;
        end
    endtask

    task automatic read_stim(output bit ok);
        int             fd;
        int             bad;
        int             store_count;
        string          line;
        cpu_pkg::word_t word;
        cpu_pkg::word_t addr;
        ok = 1'b0;
        bad = 0;
        fd = $fopen("tb/cpu_stim.txt", "r");
        if (fd == 0)
            return;
        next_line(fd, line);
        bad += ($sscanf(line, "%h", prog_len) != 1);
        for (int i = 0; i < prog_len && i < mem_words; i++)
        begin
            next_line(fd, line);
            bad += ($sscanf(line, "%h", word) != 1);
            mem[i] = word;
        end
        next_line(fd, line);
        bad += ($sscanf(line, "%h", store_count) != 1);
        for (int i = 0; i < store_count; i++)
        begin
            next_line(fd, line);
            bad += ($sscanf(line, "%h %h", addr, word) != 2);
            exp_addr.push_back(addr);
            exp_data.push_back(word);
        end
        next_line(fd, line);
        bad += ($sscanf(line, "%h", halt_addr) != 1);
        $fclose(fd);
        ok = (bad == 0) && (prog_len > 0) && (prog_len <= mem_words);
    endtask

    // memory model with one cycle of read latency; stores are checked as they happen.
    always @(negedge clock)
    begin
        if (read_pending)
            mem_rdata = mem[read_addr[7:0]];
        read_pending = mem_req.re;
        read_addr = mem_req.addr;
        if (mem_req.re)
            last_read_addr = mem_req.addr;
        if (mem_req.we)
        begin
            mem[mem_req.addr[7:0]] = mem_req.wdata;
            check_store(mem_req.addr, mem_req.wdata);
        end
    end

    initial
    begin
        void'($urandom(43818));
        rst = 1'b1;
        mem_rdata = '0;
        read_pending = 1'b0;
        read_addr = '0;
        last_read_addr = '0;
        stores_seen = 0;
        error_count = 0;
        read_stim(stim_ok);
        if (!stim_ok)
        begin
            $display("could not read the program and expected stores from tb/cpu_stim.txt");
            $display("sim failed");
        end
        else
        begin
            for (int i = prog_len; i < mem_words; i++)
                mem[i] = $urandom(); // words outside the program are never fetched.
            cycle_limit = prog_len * 4 * 8 + 100;
            repeat (3) @(posedge clock);
            @(negedge clock);
            rst = 1'b0;
            check_value("halted", 32'd0, halted);
            check_value("mem_req.we", 32'd0, mem_req.we);
            check_value("mem_req.re", 32'd1, mem_req.re);
            check_value("mem_req.addr of first fetch", 32'd0, mem_req.addr);
            while (halted !== 1'b1 && cycle_count < cycle_limit)
                @(negedge clock);
            if (halted !== 1'b1)
            begin
                error_count++;
                $display("timeout: the CPU never halted within %0d cycles", cycle_limit);
            end
            else
            begin
                if (stores_seen < exp_addr.size())
                begin
                    error_count++;
                    $display("the CPU halted after only %0d of %0d expected stores",
                             stores_seen, exp_addr.size());
                end
                check_value("mem_req.addr of last fetch", halt_addr, last_read_addr);
                repeat (halt_cycles)
                begin
                    @(negedge clock);
                    check_value("halted", 32'd1, halted); // no store may follow either.
                end
            end
            $display("%0d errors, %0d of %0d stores seen, %0d cycles run",
                     error_count, stores_seen, exp_addr.size(), cycle_count);
            if (error_count == 0)
                $display("sim passed");
            else
                $display("sim failed");
        end
        $finish;
    end

endmodule

// File: tb/cpu_stim.txt
# program length, then one hex instruction word per line from address 0,
# then the store count, one "address data" pair per store, and the halt address.
0000002F
56782005 // 00 ldi r1, 0x5678
12342006 // 01 ldhi r1, 0x1234
F0F04005 // 02 ldi r2, 0xf0f0
0F0F4006 // 03 ldhi r2, 0x0f0f
0080E005 // 04 ldi r7, 0x80
00006880 // 05 add r3, r1, r2
00001D87 // 06 store r3 to [r7]
0081E005 // 07 ldi r7, 0x81
00006881 // 08 sub r3, r1, r2
00001D87 // 09 store r3 to [r7]
0082E005 // 0a ldi r7, 0x82
00006882 // 0b and r3, r1, r2
00001D87 // 0c store r3 to [r7]
0083E005 // 0d ldi r7, 0x83
00006883 // 0e or r3, r1, r2
00001D87 // 0f store r3 to [r7]
0BADC005 // 10 ldi r6, 0x0bad as the not-taken marker
FFFF8006 // 11 ldhi r4, 0xffff
0084E005 // 12 ldi r7, 0x84
00007080 // 13 add r3, r1, r4 with carry into f3
0002018A // 14 brf f3, +2 taken
00001F07 // 15 store r6 to [r7] skipped
00001D87 // 16 store r3 to [r7]
0085E005 // 17 ldi r7, 0x85
00006501 // 18 sub r3, r2, r1 with borrow into f3
0002018A // 19 brf f3, +2 taken
00001F07 // 1a store r6 to [r7] skipped
00001D87 // 1b store r3 to [r7]
0086E005 // 1c ldi r7, 0x86
0000A889 // 1d cmplt f5, r1, r2 false
0002028A // 1e brf f5, +2 not taken
00001F07 // 1f store r6 to [r7]
00001D87 // 20 store r3 to [r7]
00006005 // 21 ldi r3, 0
0001C005 // 22 ldi r6, 1
0005A005 // 23 ldi r5, 5
00007980 // 24 add r3, r3, r6
00009589 // 25 cmplt f4, r3, r5
FFFE020A // 26 brf f4, -2 back to 24
0087E005 // 27 ldi r7, 0x87
00001D87 // 28 store r3 to [r7]
0088E005 // 29 ldi r7, 0x88
00001C87 // 2a store r1 to [r7]
00009C08 // 2b load r4 from [r7]
00008A04 // 2c xor r4, r4, r2
00001E07 // 2d store r4 to [r7]
0000000B // 2e halt
0000000B
00000080 21444768 // 0x12345678 + 0x0f0ff0f0
00000081 03246588 // 0x12345678 - 0x0f0ff0f0
00000082 02045070 // and
00000083 1F3FF6F8 // or
00000084 12335678 // 0x12345678 + 0xffff0000, carry out
00000085 FCDB9A78 // 0x0f0ff0f0 - 0x12345678, borrow
00000086 00000BAD // not-taken marker
00000086 FCDB9A78 // r3 unchanged by the compare
00000087 00000005 // loop counter after five passes
00000088 12345678 // value stored before the load
00000088 1D3BA688 // loaded value xor 0x0f0ff0f0
0000002E

// File: sources.f
src/cpu_pkg.sv
src/reg_bank.sv
src/alu.sv
src/cpu_control.sv
src/cpu.sv
tb/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

sources:
  - src/cpu_pkg.sv
  - src/reg_bank.sv
  - src/alu.sv
  - src/cpu_control.sv
  - src/cpu.sv
  - target: simulation
    files:
      - tb/tb_cpu.sv
